// File: Makefile
# Verilator build and run for the afifo_chain testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= afifo_chain_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

# sources come from the file list, option lines are skipped
SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator status is not trusted, the log decides
run: $(BIN)
	@$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx 'STATUS: PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/afifo.sv
`timescale 1ns/1ps
`default_nettype none

module afifo (
    input  logic             rst_n,

    // write port
    input  logic             w_clk,
    input  logic             w_trigger,
    input  afifo_pkg::data_t w_data,
    output logic             w_ready,

    // read port with first-word fall-through
    input  logic             r_clk,
    input  logic             r_trigger,
    output afifo_pkg::data_t r_data,
    output logic             r_ready
);
    import afifo_pkg::*;

    // storage
    data_t mem [STAGE_DEPTH];

    // write domain state
    ptr_t w_bin;
    ptr_t w_gray;
    ptr_t w_bin_next;
    ptr_t w_gray_next;
    logic w_fire;
    logic w_full;

    // read pointer as seen from the write domain
    ptr_t rq_gray;

    // read domain state
    ptr_t r_bin;
    ptr_t r_gray;
    ptr_t r_bin_next;
    ptr_t r_gray_next;
    logic r_fire;
    logic r_empty;

    // write pointer as seen from the read domain
    ptr_t wq_gray;
    ptr_t wq_bin;

    // write side

    assign w_fire      = w_trigger && !w_full;
    assign w_bin_next  = w_bin + ptr_t'(w_fire);
    assign w_gray_next = bin2gray(w_bin_next);

    always_ff @(posedge w_clk or negedge rst_n) begin
        if (!rst_n) begin
            w_bin  <= '0;
            w_gray <= '0;
        end else begin
            w_bin  <= w_bin_next;
            w_gray <= w_gray_next;
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_fire) begin
            mem[w_bin[ADDR_W-1:0]] <= w_data;
        end
    end

    // full is judged on the next pointer so the write that fills the
    // stage also drops w_ready at the same edge
    always_ff @(posedge w_clk or negedge rst_n) begin
        if (!rst_n) begin
            w_full <= 1'b0;
        end else begin
            w_full <= (w_gray_next == (rq_gray ^ GRAY_LAP));
        end
    end

    assign w_ready = !w_full;

    // pointer crossings

    // write pointer into the read domain
    ptr_sync u_sync_w2r (
        .clk     (r_clk),
        .rst_n   (rst_n),
        .ptr_in  (w_gray),
        .ptr_out (wq_gray)
    );

    // read pointer into the write domain
    ptr_sync u_sync_r2w (
        .clk     (w_clk),
        .rst_n   (rst_n),
        .ptr_in  (r_gray),
        .ptr_out (rq_gray)
    );

    // read side

    assign r_fire      = r_trigger && !r_empty;
    assign r_bin_next  = r_bin + ptr_t'(r_fire);
    assign r_gray_next = bin2gray(r_bin_next);

    always_ff @(posedge r_clk or negedge rst_n) begin
        if (!rst_n) begin
            r_bin  <= '0;
            r_gray <= '0;
        end else begin
            r_bin  <= r_bin_next;
            r_gray <= r_gray_next;
        end
    end

    // empty follows the same next-pointer trick; a new word shows up
    // two sync edges plus this compare after it was written
    always_ff @(posedge r_clk or negedge rst_n) begin
        if (!rst_n) begin
            r_empty <= 1'b1;
        end else begin
            r_empty <= (r_gray_next == wq_gray);
        end
    end

    assign r_ready = !r_empty;

    // oldest word is always on the output
    assign r_data  = mem[r_bin[ADDR_W-1:0]];

    // checks

    assign wq_bin = gray2bin(wq_gray);

    // a word accepted into the stage must be fully defined
    a_w_data_known: assert property (
        @(posedge w_clk) disable iff (!rst_n)
        w_fire |-> !$isunknown(w_data)
    ) else $error("afifo: unknown w_data accepted at pointer %0d", w_bin);

    // the read pointer trails the synchronized write pointer by at most one
    // stage worth of words and never overtakes it
    a_r_behind_w: assert property (
        @(posedge r_clk) disable iff (!rst_n)
        ptr_t'(wq_bin - r_bin) <= ptr_t'(STAGE_DEPTH)
    ) else $error("afifo: read pointer %0d passed synced write pointer %0d",
                  r_bin, wq_bin);

endmodule

`default_nettype wire

// File: design/afifo_chain.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_chain #(
    parameter int n_stages = afifo_pkg::CHAIN_N
) (
    input  logic                         rst_n,

    // propagation side with its flags in the prop_clk domain
    input  logic                         prop_clk,
    output logic                         prop_w_ready,
    output logic                         prop_r_ready,

    // write port
    input  logic                         w_clk,
    input  logic                         w_trigger,
    input  logic [afifo_pkg::DATA_W-1:0] w_data,
    output logic                         w_ready,

    // read port
    input  logic                         r_clk,
    input  logic                         r_trigger,
    output logic [afifo_pkg::DATA_W-1:0] r_data,
    output logic                         r_ready
);
    import afifo_pkg::*;

    // the half-buffer flags pick the two middle stages
    if ((n_stages < 2) || ((n_stages % 2) != 0)) begin : g_bad_n_stages
        $error("afifo_chain: n_stages must be even and at least 2, got %0d",
               n_stages);
    end

    // per-stage port nets
    logic  stg_w_clk     [n_stages];
    logic  stg_w_trigger [n_stages];
    data_t stg_w_data    [n_stages];
    logic  stg_w_ready   [n_stages];
    logic  stg_r_clk     [n_stages];
    logic  stg_r_trigger [n_stages];
    data_t stg_r_data    [n_stages];
    logic  stg_r_ready   [n_stages];

    for (genvar i = 0; i < n_stages; i++) begin : g_stage

        afifo u_afifo (
            .rst_n     (rst_n),
            .w_clk     (stg_w_clk[i]),
            .w_trigger (stg_w_trigger[i]),
            .w_data    (stg_w_data[i]),
            .w_ready   (stg_w_ready[i]),
            .r_clk     (stg_r_clk[i]),
            .r_trigger (stg_r_trigger[i]),
            .r_data    (stg_r_data[i]),
            .r_ready   (stg_r_ready[i])
        );

        // write side; only the head stage faces the outside writer
        if (i == 0) begin : g_w_head
            assign stg_w_clk[i]     = w_clk;
            assign stg_w_trigger[i] = w_trigger;
            assign stg_w_data[i]    = w_data;
        end else begin : g_w_link
            // upstream holding a word is the write request
            assign stg_w_clk[i]     = prop_clk;
            assign stg_w_trigger[i] = stg_r_ready[i-1];
            assign stg_w_data[i]    = stg_r_data[i-1];
        end

        // read side; only the tail stage faces the outside reader
        if (i == n_stages - 1) begin : g_r_tail
            assign stg_r_clk[i]     = r_clk;
            assign stg_r_trigger[i] = r_trigger;
        end else begin : g_r_link
            // downstream room pops the word, so both sides fire on the
            // same prop_clk edge and nothing is lost or doubled
            assign stg_r_clk[i]     = prop_clk;
            assign stg_r_trigger[i] = stg_w_ready[i+1];
        end
    end

    // outer ports
    assign w_ready = stg_w_ready[0];
    assign r_data  = stg_r_data[n_stages-1];
    assign r_ready = stg_r_ready[n_stages-1];

    // left half can take a full burst once the middle-left stage is empty
    // and both middle-stage flags already live in prop_clk
    assign prop_w_ready = !stg_r_ready[n_stages/2 - 1];

    // right half holds a full burst once the middle-right stage is full
    assign prop_r_ready = !stg_w_ready[n_stages/2];

endmodule

`default_nettype wire

// File: design/afifo_pkg.sv
`default_nettype none

package afifo_pkg;

    // word and stage geometry
    localparam int DATA_W      = 16;
    localparam int ADDR_W      = 2;
    localparam int STAGE_DEPTH = 1 << ADDR_W;

    // the default chain length must stay even
    localparam int CHAIN_N     = 2;

    // flops per pointer synchronizer
    localparam int SYNC_STAGES = 2;

    typedef logic [DATA_W-1:0] data_t;

    // extra msb is the wrap bit
    typedef logic [ADDR_W:0]   ptr_t;

    // a gray pointer one full lap ahead differs in its two top bits
    localparam ptr_t GRAY_LAP  = ptr_t'(3 << (ADDR_W - 1));

    function automatic ptr_t bin2gray(input ptr_t b);
        return b ^ (b >> 1);
    endfunction

    function automatic ptr_t gray2bin(input ptr_t g);
        ptr_t b;
        b[ADDR_W] = g[ADDR_W];
        for (int i = ADDR_W - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

endpackage

`default_nettype wire

// File: design/ptr_sync.sv
`timescale 1ns/1ps
`default_nettype none

module ptr_sync (
    input  logic            clk,
    input  logic            rst_n,
    input  afifo_pkg::ptr_t ptr_in,
    output afifo_pkg::ptr_t ptr_out
);
    import afifo_pkg::*;

    // sync_q[0] takes the asynchronous sample and the last entry is safe to use
    ptr_t sync_q [SYNC_STAGES];

    // binary view of the raw capture for the step check
    ptr_t cap_bin;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= ptr_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign ptr_out = sync_q[SYNC_STAGES-1];

    assign cap_bin = gray2bin(sync_q[0]);

    // the source walks a gray sequence, so every capture is a real pointer value
    // that lies a bounded step ahead of the previous one; a torn multi-bit
    // capture would show up as a backward jump or a step larger than the buffer
    a_gray_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        ptr_t'(cap_bin - $past(cap_bin)) <= ptr_t'(STAGE_DEPTH)
    ) else $error("ptr_sync: captured pointer jumped from %0d to %0d",
                  $past(cap_bin), cap_bin);

endmodule

`default_nettype wire

// File: dv/afifo_chain_tb.sv
`timescale 1ns/1ps
`default_nettype none

module afifo_chain_tb;
    import afifo_pkg::*;

    localparam int CAPACITY    = CHAIN_N * STAGE_DEPTH;
    localparam int N_RANDOM    = 200;
    localparam int TOTAL_WORDS = N_RANDOM + CAPACITY;
    localparam int SLOW_PERIOD = 14;
    localparam int TIMEOUT_NS  = TOTAL_WORDS * SLOW_PERIOD * 20 + 2000;

    logic  rst_n;
    logic  w_clk;
    logic  r_clk;
    logic  prop_clk;
    logic  w_trigger;
    data_t w_data;
    logic  w_ready;
    logic  r_trigger;
    data_t r_data;
    logic  r_ready;
    logic  prop_w_ready;
    logic  prop_r_ready;

    // reference model of the whole buffer
    data_t model_q [$];
    data_t exp_head;
    int    model_count;
    int    write_count;
    int    read_count;

    int    seed;
    string test_name;
    int    check_fails;
    int    tests_passed;
    int    tests_failed;

    afifo_chain DUT (
        .rst_n        (rst_n),
        .prop_clk     (prop_clk),
        .prop_w_ready (prop_w_ready),
        .prop_r_ready (prop_r_ready),
        .w_clk        (w_clk),
        .w_trigger    (w_trigger),
        .w_data       (w_data),
        .w_ready      (w_ready),
        .r_clk        (r_clk),
        .r_trigger    (r_trigger),
        .r_data       (r_data),
        .r_ready      (r_ready)
    );

    initial begin
        w_clk = 1'b0;
        forever #5 w_clk = ~w_clk;
    end

    initial begin
        r_clk = 1'b0;
        forever #7 r_clk = ~r_clk;
    end

    initial begin
        prop_clk = 1'b0;
        forever #3 prop_clk = ~prop_clk;
    end

    function automatic void update_head();
        model_count = model_q.size();
        exp_head    = (model_count != 0) ? model_q[0] : '0;
    endfunction

    // record accepted writes and reads
    always @(posedge w_clk) begin
        if (rst_n && w_trigger && w_ready) begin
            model_q.push_back(w_data);
            write_count++;
            update_head();
        end
    end

    always @(posedge r_clk) begin
        if (rst_n && r_trigger && r_ready) begin
            if (model_q.size() != 0) begin
                void'(model_q.pop_front());
            end
            read_count++;
            update_head();
        end
    end

    a_read_matches_head: assert property (
        @(posedge r_clk) disable iff (!rst_n)
        (r_trigger && r_ready) |-> (r_data == exp_head)
    ) else begin
        $display("Fail %s: expected %h, actual %h", test_name,
                 $sampled(exp_head), $sampled(r_data));
        check_fails++;
    end

    a_read_needs_word: assert property (
        @(posedge r_clk) disable iff (!rst_n)
        r_ready |-> (model_count != 0)
    ) else begin
        $display("%s: r_ready is high while no word is stored", test_name);
        check_fails++;
    end

    a_write_has_room: assert property (
        @(posedge w_clk) disable iff (!rst_n)
        (w_trigger && w_ready) |-> (model_count < CAPACITY)
    ) else begin
        $display("%s: write accepted with the buffer already full", test_name);
        check_fails++;
    end

    task automatic check_bit(input string what, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("Fail %s: %s expected %b, actual %b", test_name, what, expected, actual);
            check_fails++;
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Fail %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
            check_fails++;
        end
    endtask

    task automatic end_test(input int fails_before);
        if (check_fails == fails_before) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: %0d check(s) failed", test_name, check_fails - fails_before);
            tests_failed++;
        end
    endtask

    // write count words, with random idle cycles when gaps is set
    task automatic write_words(input int count, input bit gaps);
        int target;
        target = write_count + count;
        @(negedge w_clk);
        while (write_count < target) begin
            w_trigger = gaps ? (($random(seed) & 3) != 0) : 1'b1;
            w_data    = data_t'($random(seed));
            @(negedge w_clk);
        end
        w_trigger = 1'b0;
    endtask

    // read until the total read count reaches target
    task automatic read_until(input int target, input bit gaps);
        @(negedge r_clk);
        while (read_count < target) begin
            r_trigger = gaps ? (($random(seed) & 3) != 0) : 1'b1;
            @(negedge r_clk);
        end
        r_trigger = 1'b0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, a handshake never completed", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int fails_before;
        int start_count;
        int low_run;

        seed         = 97810;
        rst_n        = 1'b0;
        w_trigger    = 1'b0;
        w_data       = '0;
        r_trigger    = 1'b0;
        write_count  = 0;
        read_count   = 0;
        check_fails  = 0;
        tests_passed = 0;
        tests_failed = 0;
        update_head();

        repeat (4) @(posedge w_clk);
        @(negedge w_clk);
        rst_n = 1'b1;

        test_name    = "reset";
        fails_before = check_fails;
        @(negedge w_clk);
        check_bit("w_ready", 1'b1, w_ready);
        check_bit("r_ready", 1'b0, r_ready);
        check_bit("prop_w_ready", 1'b1, prop_w_ready);
        check_bit("prop_r_ready", 1'b0, prop_r_ready);
        end_test(fails_before);

        test_name    = "order";
        fails_before = check_fails;
        fork
            write_words(N_RANDOM, 1'b1);
            read_until(N_RANDOM, 1'b1);
        join
        // keep the reader open so a surplus word would be counted
        @(negedge r_clk);
        r_trigger = 1'b1;
        repeat (20) @(negedge r_clk);
        r_trigger = 1'b0;
        check_value("read count", write_count, read_count);
        end_test(fails_before);

        // fill with the reader stalled until w_ready has stayed low long enough
        test_name    = "capacity";
        fails_before = check_fails;
        start_count  = write_count;
        low_run      = 0;
        @(negedge w_clk);
        while (low_run < 50) begin
            w_trigger = 1'b1;
            w_data    = data_t'($random(seed));
            @(negedge w_clk);
            low_run   = w_ready ? 0 : low_run + 1;
        end
        w_trigger = 1'b0;
        check_value("accepted words", CAPACITY, write_count - start_count);
        end_test(fails_before);

        test_name    = "half_flags";
        fails_before = check_fails;
        @(negedge prop_clk);
        check_bit("prop_r_ready when full", 1'b1, prop_r_ready);
        check_bit("prop_w_ready when full", 1'b0, prop_w_ready);
        read_until(write_count, 1'b0);
        repeat (20) @(negedge prop_clk);
        check_bit("prop_w_ready when empty", 1'b1, prop_w_ready);
        check_bit("prop_r_ready when empty", 1'b0, prop_r_ready);
        end_test(fails_before);

        test_name    = "drain";
        fails_before = check_fails;
        repeat (20) begin
            @(negedge r_clk);
            check_bit("r_ready", 1'b0, r_ready);
        end
        @(negedge w_clk);
        check_bit("w_ready", 1'b1, w_ready);
        end_test(fails_before);

        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, check_fails);
        if (tests_failed == 0 && check_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/afifo_pkg.sv
design/ptr_sync.sv
design/afifo.sv
design/afifo_chain.sv
dv/afifo_chain_tb.sv
